//--- dds.f
+incdir+.
dds_pkg.sv
quarter_wave_rom.sv
cos_lookup.sv
phase_pipeline.sv
dds.sv
dds_tb.sv

//--- Makefile
# Verilator build and run for the cosine DDS
# every variable can be overridden from the command line

VERILATOR ?= verilator
FILELIST  ?= dds.f
TB_TOP    ?= dds_tb
RTL_TOP   ?= dds
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# the simulation exit code is ignored, the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dds_tb.sv
// ***********************************************************
// self-checking testbench for the multi-lane cosine DDS
// drives increments and random back-pressure, tracks phase
// in a model and checks every accepted sample
// ***********************************************************
`timescale 1ns/1ps
`include "dds_macros.svh"

module dds_tb;

  localparam int PHASE_BITS = `DDS_PHASE_BITS;
  localparam int SAMPLE_WIDTH = `DDS_SAMPLE_WIDTH;
  localparam int LANES = `DDS_PARALLEL_SAMPLES;
  localparam int CLK_PERIOD = 10;
  localparam int PHASE_CYCLES = 400;
  localparam int MIN_WORDS = 2 * PHASE_CYCLES;
  // reset, latency check, zero run, four frequency runs, stall test, drain
  localparam int TEST_CYCLES = 5 + 4 + 20 + 4 * (2 + PHASE_CYCLES) + 30 + 10;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 500) * CLK_PERIOD;
  localparam real PI = 3.14159265358979;

  logic clk;
  logic reset;
  logic [PHASE_BITS-1:0] phase_inc;
  logic phase_inc_valid;
  logic [SAMPLE_WIDTH*LANES-1:0] cos_data;
  logic cos_valid;
  logic cos_ready;

  logic [31:0] rng;
  string test_name;
  int word_count;

  // model state, one queue entry per lane phase still in flight
  logic [PHASE_BITS-1:0] model_base;
  logic [PHASE_BITS-1:0] model_inc;
  logic [PHASE_BITS-1:0] phase_q [$];
  logic stalled_prev;
  logic [SAMPLE_WIDTH*LANES-1:0] held_data;

  dds DUT (
    .clk             (clk),
    .reset           (reset),
    .phase_inc       (phase_inc),
    .phase_inc_valid (phase_inc_valid),
    .cos_data        (cos_data),
    .cos_valid       (cos_valid),
    .cos_ready       (cos_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // 32-bit xorshift step
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ideal cosine at the top 10 phase bits, rounded to the nearest integer
  function automatic int expected_sample(input dds_pkg::phase_word_t w);
    int q;
    real v;
    q = int'({w.fields.quadrant, w.fields.index});
    v = real'((1 << (SAMPLE_WIDTH - 1)) - 1) *
        $cos(2.0 * PI * real'(q) / real'(1 << `DDS_WAVE_ADDR_BITS));
    return $rtoi($floor(v + 0.5));
  endfunction

  // once the output holds a word it must keep one
  valid_stays_high: assert property (
    @(posedge clk) disable iff (reset) cos_valid |=> cos_valid
  ) else report_failure($sformatf("Error: %s valid_stays_high expected 1 actual 0",
                                  test_name));

  // all values are taken before the edge updates them, so the model
  // sees exactly what the DUT registers see
  always @(posedge clk) begin : model_and_check
    dds_pkg::phase_word_t word;
    dds_pkg::sample_t lane_value;
    int expected;
    int actual;
    int tol;
    if (reset) begin
      model_base = '0;
      model_inc = '0;
      phase_q.delete();
      stalled_prev = 1'b0;
    end else begin
      // a stalled word must still be there one cycle later
      if (stalled_prev) begin
        assert (cos_data == held_data)
          else report_failure($sformatf("Error: %s stall_hold expected %h actual %h",
                                        test_name, held_data, cos_data));
      end
      if (cos_valid && cos_ready) begin
        assert (phase_q.size() >= LANES)
          else report_failure("output word accepted with no word expected in flight");
        for (int i = 0; i < LANES; i++) begin
          word.raw = phase_q.pop_front();
          lane_value = cos_data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
          actual = lane_value;
          expected = expected_sample(word);
          // phase zero maps to the exact table peak
          tol = (word.raw[PHASE_BITS-1 -: `DDS_WAVE_ADDR_BITS] == '0) ? 0 : 1;
          assert (actual - expected <= tol && expected - actual <= tol)
            else report_failure($sformatf("Error: %s lane %0d expected %0d actual %0d",
                                          test_name, i, expected, actual));
        end
        word_count++;
      end
      // a new word enters whenever the pipe advances
      if (!cos_valid || cos_ready) begin
        for (int i = 0; i < LANES; i++) begin
          phase_q.push_back(PHASE_BITS'(model_base + model_inc * PHASE_BITS'(i)));
        end
        model_base = PHASE_BITS'(model_base + model_inc * PHASE_BITS'(LANES));
      end
      if (phase_inc_valid) begin
        model_inc = phase_inc;
      end
      stalled_prev = cos_valid && !cos_ready;
      held_data = cos_data;
    end
  end

  task automatic load_increment(input logic [PHASE_BITS-1:0] inc);
    @(posedge clk);
    phase_inc <= inc;
    phase_inc_valid <= 1'b1;
    @(posedge clk);
    phase_inc_valid <= 1'b0;
  endtask

  // ready is high about three cycles out of four
  task automatic run_random_ready(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      rng = next_random(rng);
      cos_ready <= (rng[1:0] != 2'b00);
    end
  endtask

  initial begin
    logic [PHASE_BITS-1:0] inc;
    rng = 32'd5152;
    word_count = 0;
    reset = 1'b1;
    phase_inc = '0;
    phase_inc_valid = 1'b0;
    cos_ready = 1'b1;
    test_name = "valid_latency";
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    // the output register fills after three advancing cycles
    @(negedge clk);
    assert (cos_valid == 1'b0)
      else report_failure("Error: valid_latency expected 0 actual 1");
    for (int k = 1; k <= 3; k++) begin
      @(posedge clk);
      @(negedge clk);
      assert (cos_valid == (k == 3))
        else report_failure($sformatf("Error: valid_latency expected %0d actual %0d",
                                      k == 3, cos_valid));
    end
    test_name <= "zero_increment";
    repeat (20) @(posedge clk);
    for (int f = 0; f < 4; f++) begin
      rng = next_random(rng);
      case (f)
        0: begin
          test_name <= "slow_increment";
          inc = 24'h004000 | (rng[23:0] & 24'h000fff);
        end
        1: begin
          test_name <= "mid_increment";
          inc = 24'h200000 | (rng[23:0] & 24'h0fffff);
        end
        2: begin
          test_name <= "near_nyquist_increment";
          inc = 24'h7f0000 | (rng[23:0] & 24'h00ffff);
        end
        default: begin
          test_name <= "small_increment";
          inc = 24'h000001 | (rng[23:0] & 24'h00000f);
        end
      endcase
      load_increment(inc);
      run_random_ready(PHASE_CYCLES);
    end
    // load a new increment while the output is held back
    test_name <= "stall_increment";
    @(posedge clk);
    cos_ready <= 1'b0;
    repeat (2) @(posedge clk);
    rng = next_random(rng);
    load_increment(24'h010000 | (rng[23:0] & 24'h00ffff));
    repeat (2) @(posedge clk);
    cos_ready <= 1'b1;
    repeat (30) @(posedge clk);
    if (word_count < MIN_WORDS) begin
      report_failure($sformatf("only %0d output words were accepted", word_count));
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired, the run did not finish in time");
  end

endmodule

//--- dds.sv
// ***********************************************************
// multi-lane cosine DDS, four samples per clock
// one phase pipeline feeds four table lookups whose results
// leave as one valid/ready word
// ***********************************************************
`timescale 1ns/1ps
`include "dds_macros.svh"

module dds (
  input  logic clk,
  input  logic reset,
  input  logic [`DDS_PHASE_BITS-1:0] phase_inc,
  input  logic phase_inc_valid,
  output logic [`DDS_SAMPLE_WIDTH*`DDS_PARALLEL_SAMPLES-1:0] cos_data,
  output logic cos_valid,
  input  logic cos_ready
);

  localparam int SAMPLE_WIDTH = `DDS_SAMPLE_WIDTH;
  localparam int LANES = `DDS_PARALLEL_SAMPLES;

  logic advance;
  dds_pkg::phase_word_t lane_phase [LANES];
  dds_pkg::sample_t lane_sample [LANES];

  // accumulator, lane phases, valid tracking and the pipeline enable
  phase_pipeline phase_pipeline_i (
    .clk             (clk),
    .reset           (reset),
    .phase_inc       (phase_inc),
    .phase_inc_valid (phase_inc_valid),
    .cos_ready       (cos_ready),
    .advance         (advance),
    .lane_phase      (lane_phase),
    .cos_valid       (cos_valid)
  );

  // all lanes share the same enable so they stay in step
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    cos_lookup cos_lookup_i (
      .clk     (clk),
      .reset   (reset),
      .advance (advance),
      .phase   (lane_phase[i]),
      .sample  (lane_sample[i])
    );

    // lane 0 lands in the low bits, it is the earliest sample
    assign cos_data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = lane_sample[i];
  end

endmodule

//--- phase_pipeline.sv
// ***********************************************************
// DDS phase pipeline and stall control
// accumulates phase, spreads it over the lanes and tracks
// which stages hold a valid word
// ***********************************************************
`timescale 1ns/1ps
`include "dds_macros.svh"

module phase_pipeline (
  input  logic clk,
  input  logic reset,
  input  logic [`DDS_PHASE_BITS-1:0] phase_inc,
  input  logic phase_inc_valid,
  input  logic cos_ready,
  output logic advance,
  output dds_pkg::phase_word_t lane_phase [`DDS_PARALLEL_SAMPLES],
  output logic cos_valid
);

  localparam int PHASE_BITS = `DDS_PHASE_BITS;
  localparam int LANES = `DDS_PARALLEL_SAMPLES;
  localparam int DEPTH = `DDS_PIPE_DEPTH;

  logic [PHASE_BITS-1:0] inc_q;
  logic [PHASE_BITS-1:0] base_q;
  logic [PHASE_BITS-1:0] lane_offset [LANES];
  logic [DEPTH-1:0] valid_q;

  // the last valid bit marks a word in the output register
  assign cos_valid = valid_q[DEPTH-1];

  // the pipe may move when the output is empty or being taken
  // every datapath register in the design uses this as its enable
  assign advance = !cos_valid || cos_ready;

  // the increment is a plain config register with no handshake
  // it loads even during a stall and is picked up by the next
  // word that enters stage 1
  always_ff @(posedge clk) begin
    if (reset) begin
      inc_q <= '0;
    end else if (phase_inc_valid) begin
      inc_q <= phase_inc;
    end
  end

  // lane i sits i increments after the base of its word
  for (genvar i = 0; i < LANES; i++) begin : g_offset
    assign lane_offset[i] = inc_q * PHASE_BITS'(i);
  end

  // stage 0 is the base phase, which steps by a full word of increments
  // last lane offset plus one more increment gives LANES * inc
  always_ff @(posedge clk) begin
    if (reset) begin
      base_q <= '0;
    end else if (advance) begin
      base_q <= base_q + lane_offset[LANES-1] + inc_q;
    end
  end

  // stage 1, one phase word per lane
  // wrap-around at 2^24 is the natural period of the accumulator
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < LANES; i++) begin
        lane_phase[i].raw <= base_q + lane_offset[i];
      end
    end
  end

  // a one enters at stage 1 and walks to the output with the data
  // a stall holds the chain, so once full it never empties again
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q <= {valid_q[DEPTH-2:0], 1'b1};
    end
  end

endmodule

//--- cos_lookup.sv
// ***********************************************************
// one cosine lane of the DDS
// folds a phase word into the quarter table, reads it and
// restores the sign of the quadrant
// ***********************************************************
`timescale 1ns/1ps
`include "dds_macros.svh"

module cos_lookup (
  input  logic clk,
  input  logic reset,
  input  logic advance,
  input  dds_pkg::phase_word_t phase,
  output dds_pkg::sample_t sample
);

  localparam int QUARTER_ADDR_BITS = `DDS_QUARTER_ADDR_BITS;

  // table address of the quarter end point, 256 for an 8-bit index
  localparam logic [QUARTER_ADDR_BITS:0] QUARTER_LEN = {1'b1, {QUARTER_ADDR_BITS{1'b0}}};

  logic [QUARTER_ADDR_BITS:0] index_ext;
  logic [QUARTER_ADDR_BITS:0] rom_addr;
  logic negate_d;
  logic negate_q;
  dds_pkg::sample_t rom_value;

  // the index widened by one bit so it can be mirrored against 256
  assign index_ext = {1'b0, phase.fields.index};

  // odd quadrants walk the table backwards
  // quadrant 1 runs from cos(pi/2) toward cos(pi), which is the table
  // read from its far end and negated
  always_comb begin
    if (phase.fields.quadrant[0]) begin
      rom_addr = QUARTER_LEN - index_ext;
    end else begin
      rom_addr = index_ext;
    end
  end

  // cosine is negative in quadrants 1 and 2 only
  assign negate_d = phase.fields.quadrant[0] ^ phase.fields.quadrant[1];

  // stage 2, the table read
  quarter_wave_rom rom_i (
    .clk     (clk),
    .advance (advance),
    .addr    (rom_addr),
    .value   (rom_value)
  );

  // the sign travels next to the ROM read so both reach stage 3
  // in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      negate_q <= 1'b0;
    end else if (advance) begin
      negate_q <= negate_d;
    end
  end

  // stage 3, signed output register
  // the table peaks at 2^17 - 1 so the negation cannot overflow
  always_ff @(posedge clk) begin
    if (advance) begin
      if (negate_q) begin
        sample <= -rom_value;
      end else begin
        sample <= rom_value;
      end
    end
  end

endmodule

//--- quarter_wave_rom.sv
// ***********************************************************
// quarter-wave cosine ROM with a registered read
// holds cos over the first quadrant, endpoints included
// ***********************************************************
`timescale 1ns/1ps
`include "dds_macros.svh"

module quarter_wave_rom (
  input  logic clk,
  input  logic advance,
  input  logic [`DDS_QUARTER_ADDR_BITS:0] addr,
  output dds_pkg::sample_t value
);

  localparam int TABLE_DEPTH = (1 << `DDS_QUARTER_ADDR_BITS) + 1;
  localparam real PI = 3.14159265358979;

  // entry k is round((2^17 - 1) * cos(2*pi*k/1024))
  // cos is never negative in this quadrant so adding one half rounds
  function automatic dds_pkg::sample_t quarter_cos(input int k);
    real angle;
    real scaled;
    angle = 2.0 * PI * real'(k) / real'(1 << `DDS_WAVE_ADDR_BITS);
    scaled = real'((1 << (`DDS_SAMPLE_WIDTH - 1)) - 1) * $cos(angle);
    return dds_pkg::sample_t'($rtoi(scaled + 0.5));
  endfunction

  dds_pkg::sample_t table_rom [TABLE_DEPTH];

  // every entry is a constant worked out at elaboration
  for (genvar k = 0; k < TABLE_DEPTH; k++) begin : g_entry
    localparam dds_pkg::sample_t ENTRY = quarter_cos(k);
    assign table_rom[k] = ENTRY;
  end

  // single registered read, frozen together with the rest of the pipe
  always_ff @(posedge clk) begin
    if (advance) begin
      value <= table_rom[addr];
    end
  end

endmodule

//--- dds_pkg.sv
// ***********************************************************
// DDS types: the two-view phase word and the output sample
// ***********************************************************
`include "dds_macros.svh"

package dds_pkg;

  // lookup view of a phase word, most significant field first
  // the fraction below the table address is simply dropped
  typedef struct packed {
    logic [`DDS_WAVE_ADDR_BITS-`DDS_QUARTER_ADDR_BITS-1:0] quadrant;
    logic [`DDS_QUARTER_ADDR_BITS-1:0] index;
    logic [`DDS_PHASE_BITS-`DDS_WAVE_ADDR_BITS-1:0] fraction;
  } phase_fields_t;

  // the accumulator writes the raw view and the lookup reads the fields,
  // both views cover the same 24 bits
  typedef union packed {
    logic [`DDS_PHASE_BITS-1:0] raw;
    phase_fields_t fields;
  } phase_word_t;

  // one signed cosine sample
  typedef logic signed [`DDS_SAMPLE_WIDTH-1:0] sample_t;

endpackage

//--- dds_macros.svh
// ***********************************************************
// DDS size definitions shared by the RTL and the testbench
// covering phase, sample, lane count and lookup widths
// ***********************************************************
`ifndef DDS_MACROS_SVH
`define DDS_MACROS_SVH

// width of the phase accumulator and of the phase increment
`define DDS_PHASE_BITS 24
// width of one signed cosine sample
`define DDS_SAMPLE_WIDTH 18
// samples produced per clock, lane 0 is first in time
`define DDS_PARALLEL_SAMPLES 4
// top phase bits that address one full cosine period
`define DDS_WAVE_ADDR_BITS 10
// index width inside one quadrant of the period
`define DDS_QUARTER_ADDR_BITS 8
// stages from the accumulator to the output register
`define DDS_PIPE_DEPTH 3

`endif
